// File: i2c_imu_master.f
common/i2c_pkg.sv
hw/i2c_phase_gen.sv
hw/i2c_txn/i2c_byte_engine.sv
hw/i2c_txn/i2c_txn_ctrl.sv
hw/i2c_imu_master.sv
dv/i2c_slave_model.sv
dv/i2c_imu_master_tb.sv

// File: Makefile
# Verilator simulation of the I2C IMU master

VERILATOR ?= verilator
TOP       ?= i2c_imu_master_tb
FILELIST  ?= i2c_imu_master.f
LOG       ?= sim.log
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST LOG BUILD_DIR"

test:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) \
		-f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/i2c_imu_master_tb.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_imu_master_tb
	import i2c_pkg::*;
();

	localparam int TIMEOUT = 60000;

	logic   clk = 1'b0;
	logic   rst_n;
	logic   start;
	logic   rw;
	byte_t  reg_addr;
	byte_t  write_data;
	burst_t burst_length;
	byte_t  read_data;
	logic   data_valid;
	logic   busy;
	logic   error;
	logic   scl;
	logic   sda_out;
	logic   sda_oe;
	logic   nack_addr;
	logic   nack_data;
	logic   sda_pull;
	wire    sda_line;

	byte_t       model [256];
	byte_t       rd_q [$];
	logic [31:0] lfsr = 32'hc345_9d54;
	int          errors = 0;
	int          checks = 0;

	// open drain, either side may pull low
	assign sda_line = ((sda_oe && !sda_out) || sda_pull) ? 1'b0 : 1'b1;

	always #5 clk = ~clk;

	i2c_imu_master i_i2c_imu_master (
		.clk          (clk),
		.rst_n        (rst_n),
		.start        (start),
		.rw           (rw),
		.reg_addr     (reg_addr),
		.write_data   (write_data),
		.burst_length (burst_length),
		.sda_in       (sda_line),
		.read_data    (read_data),
		.data_valid   (data_valid),
		.busy         (busy),
		.error        (error),
		.scl          (scl),
		.sda_out      (sda_out),
		.sda_oe       (sda_oe)
	);

	i2c_slave_model i_slave (
		.scl       (scl),
		.sda       (sda_line),
		.nack_addr (nack_addr),
		.nack_data (nack_data),
		.sda_pull  (sda_pull)
	);

	always @(negedge clk) begin
		if (data_valid)
			rd_q.push_back(read_data); // collect read bytes
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32,22,2,1
	endfunction

	task automatic get_rand(input int nbits, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < nbits; i++) begin
			lfsr = lfsr_step(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %s got %0h expected %0h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		@(negedge clk);
		while (busy && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (busy) begin
			errors++;
			$display("timeout waiting for busy to fall at %0t", $time);
		end else begin
			// a stop leaves SCL high and SDA released
			check_val("scl", 32'(scl), 32'h1);
			check_val("sda_out", 32'(sda_out), 32'h1);
			check_val("sda_oe", 32'(sda_oe), 32'h0);
		end
	endtask

	task automatic pulse_start(input logic t_rw, input byte_t t_reg, input byte_t t_wd,
	                           input burst_t t_len);
		@(posedge clk);
		start        <= 1'b1;
		rw           <= t_rw;
		reg_addr     <= t_reg;
		write_data   <= t_wd;
		burst_length <= t_len;
		@(posedge clk);
		start <= 1'b0;
	endtask

	task automatic run_txn(input logic t_rw, input byte_t t_reg, input byte_t t_wd,
	                       input burst_t t_len);
		rd_q.delete();
		pulse_start(t_rw, t_reg, t_wd, t_len);
		wait_idle();
	endtask

	task automatic read_check(input byte_t t_reg, input burst_t t_len);
		int n_exp;
		n_exp = (t_len == '0) ? 1 : int'(t_len);
		run_txn(1'b1, t_reg, 8'h00, t_len);
		check_val("error", 32'(error), 32'h0);
		check_val("data_valid count", 32'(rd_q.size()), 32'(n_exp));
		for (int k = 0; k < n_exp && k < rd_q.size(); k++)
			check_val("read_data", 32'(rd_q[k]), 32'(model[byte_t'(int'(t_reg) + k)]));
	endtask

	task automatic check_memory();
		int bad;
		bad = 0;
		for (int i = 0; i < 256; i++) begin
			if (i_slave.mem[i] !== model[i])
				bad++;
		end
		check_val("slave memory mismatches", 32'(bad), 32'h0);
	endtask

	initial begin
		logic [31:0] r;
		logic [31:0] a;
		logic [31:0] d;
		int          n;
		rst_n        = 1'b0;
		start        = 1'b0;
		rw           = 1'b0;
		reg_addr     = '0;
		write_data   = '0;
		burst_length = '0;
		nack_addr    = 1'b0;
		nack_data    = 1'b0;
		for (int i = 0; i < 256; i++) begin
			model[i]       = byte_t'(i * 29 + 71);
			i_slave.mem[i] = model[i];
		end
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_val("scl", 32'(scl), 32'h1);
		check_val("sda_out", 32'(sda_out), 32'h1);
		check_val("sda_oe", 32'(sda_oe), 32'h0);
		check_val("busy", 32'(busy), 32'h0);
		check_val("error", 32'(error), 32'h0);
		check_val("data_valid", 32'(data_valid), 32'h0);

		// write, then read each register back
		for (int t = 0; t < 6; t++) begin
			get_rand(8, a);
			get_rand(8, d);
			run_txn(1'b0, a[7:0], d[7:0], 4'd0);
			check_val("error", 32'(error), 32'h0);
			model[a[7:0]] = d[7:0];
			read_check(a[7:0], 4'd1);
		end

		// bursts, length 0 included
		for (int t = 0; t < 5; t++) begin
			get_rand(8, a);
			get_rand(4, r);
			read_check(a[7:0], r[3:0]);
		end
		get_rand(8, a);
		read_check(a[7:0], 4'd0);

		// address refused
		for (int t = 0; t < 2; t++) begin
			get_rand(1, r);
			get_rand(8, a);
			get_rand(8, d);
			@(posedge clk);
			nack_addr <= 1'b1;
			run_txn(r[0], a[7:0], d[7:0], 4'd3);
			check_val("error", 32'(error), 32'h1);
			check_val("data_valid count", 32'(rd_q.size()), 32'h0);
			check_memory();
			@(posedge clk);
			nack_addr <= 1'b0;
		end

		// data byte refused, error clears on the next start
		get_rand(8, a);
		get_rand(8, d);
		@(posedge clk);
		nack_data <= 1'b1;
		run_txn(1'b0, a[7:0], d[7:0], 4'd0);
		check_val("error", 32'(error), 32'h1);
		check_memory();
		@(posedge clk);
		nack_data <= 1'b0;
		rd_q.delete();
		pulse_start(1'b1, a[7:0], 8'h00, 4'd1);
		@(negedge clk);
		check_val("error after start", 32'(error), 32'h0);
		wait_idle();
		check_val("error", 32'(error), 32'h0);
		check_val("data_valid count", 32'(rd_q.size()), 32'h1);
		check_val("read_data", 32'(rd_q.size() > 0 ? rd_q[0] : 8'h00), 32'(model[a[7:0]]));

		// second start in mid transaction is ignored
		get_rand(8, a);
		get_rand(8, d);
		rd_q.delete();
		pulse_start(1'b0, a[7:0], d[7:0], 4'd0);
		for (n = 0; n < 200; n++)
			@(posedge clk);
		start        <= 1'b1;
		rw           <= 1'b1;
		reg_addr     <= a[7:0] + 8'd1;
		write_data   <= ~d[7:0];
		burst_length <= 4'd3;
		@(posedge clk);
		start <= 1'b0;
		wait_idle();
		model[a[7:0]] = d[7:0];
		check_val("error", 32'(error), 32'h0);
		check_val("data_valid count", 32'(rd_q.size()), 32'h0);
		n = 0;
		for (int i = 0; i < 50; i++) begin
			@(negedge clk);
			if (busy)
				n++;
		end
		check_val("busy cycles after finish", 32'(n), 32'h0);
		read_check(a[7:0], 4'd2);
		check_memory();

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/i2c_slave_model.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_slave_model
	import i2c_pkg::*;
(
	input  wire  scl,
	input  wire  sda,
	input  wire  nack_addr,
	input  wire  nack_data,
	output logic sda_pull
);

	typedef enum logic [2:0] {M_IDLE, M_ADDR, M_REG, M_WR, M_RD} mode_e;

	byte_t mem [256];
	mode_e mode = M_IDLE;
	byte_t ptr = '0;
	byte_t shreg = '0;
	byte_t tx = '0;
	int    slot = 0;
	logic  skip = 1'b0;   // ignore the SCL fall that closes a (re)start
	logic  matched = 1'b0;
	logic  rw_bit = 1'b0;
	logic  mack = 1'b1;   // master ack on a read byte, 1 = NACK
	logic  scl_q = 1'b1;  // line levels seen at the previous edge
	logic  sda_q = 1'b1;

	initial sda_pull = 1'b0;

	// every edge of either line
	always @(posedge scl or negedge scl or posedge sda or negedge sda) begin
		if (sda !== sda_q && scl === 1'b1) begin
			sda_pull = 1'b0;
			if (sda === 1'b0) begin
				mode = M_ADDR; // start or repeated start
				slot = 0;
				skip = 1'b1;
			end else begin
				mode = M_IDLE; // stop
			end
		end else if (scl === 1'b1 && scl_q !== 1'b1) begin
			if (mode != M_IDLE) begin
				if (slot < 8) begin
					if (mode != M_RD)
						shreg = {shreg[6:0], sda};
				end else if (mode == M_RD) begin
					mack = sda;
				end
			end
		end else if (scl === 1'b0 && scl_q !== 1'b0) begin
			if (mode != M_IDLE) begin
				if (skip) begin
					skip = 1'b0;
				end else if (slot == 7) begin
					slot = 8; // ack slot follows
					case (mode)
						M_ADDR: begin
							matched  = (shreg[7:1] == SLAVE_ADDR) && !nack_addr;
							rw_bit   = shreg[0];
							sda_pull = matched;
						end
						M_REG: begin
							ptr      = shreg;
							sda_pull = 1'b1;
						end
						M_WR: begin
							if (!nack_data) begin
								mem[ptr] = shreg;
								ptr      = ptr + 8'd1;
								sda_pull = 1'b1;
							end
						end
						default: sda_pull = 1'b0; // master acks a read byte
					endcase
				end else if (slot == 8) begin
					slot     = 0;
					sda_pull = 1'b0;
					if (mode == M_ADDR) begin
						if (!matched)
							mode = M_IDLE;
						else
							mode = rw_bit ? M_RD : M_REG;
					end else if (mode == M_REG) begin
						mode = M_WR;
					end else if (mode == M_RD && mack) begin
						mode = M_IDLE;
					end
					if (mode == M_RD) begin
						tx       = mem[ptr];
						ptr      = ptr + 8'd1;
						sda_pull = !tx[7];
					end
				end else begin
					slot = slot + 1;
					if (mode == M_RD)
						sda_pull = !tx[7 - slot];
				end
			end
		end
		scl_q = scl;
		sda_q = sda;
	end

endmodule

`default_nettype wire

// File: hw/i2c_imu_master.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_imu_master
	import i2c_pkg::*;
(
	input  wire    clk,
	input  wire    rst_n,
	input  wire    start,
	input  wire    rw,
	input  byte_t  reg_addr,
	input  byte_t  write_data,
	input  burst_t burst_length,
	input  wire    sda_in,
	output byte_t  read_data,
	output logic   data_valid,
	output logic   busy,
	output logic   error,
	output logic   scl,
	output logic   sda_out,
	output logic   sda_oe
);

	// controller <-> byte engine
	logic     cmd_valid;
	i2c_cmd_e cmd;
	byte_t    tx_byte;
	logic     ack_bit;
	logic     cmd_done;
	byte_t    rx_byte;
	logic     ack_in;

	// byte engine <-> phase generator
	logic     run;
	logic     tick;
	phase_t   phase;

	i2c_txn_ctrl i_i2c_txn_ctrl (
		.clk          (clk),
		.rst_n        (rst_n),
		.start        (start),
		.rw           (rw),
		.reg_addr     (reg_addr),
		.write_data   (write_data),
		.burst_length (burst_length),
		.cmd_done     (cmd_done),
		.rx_byte      (rx_byte),
		.ack_in       (ack_in),
		.cmd_valid    (cmd_valid),
		.cmd          (cmd),
		.tx_byte      (tx_byte),
		.ack_bit      (ack_bit),
		.read_data    (read_data),
		.data_valid   (data_valid),
		.busy         (busy),
		.error        (error)
	);

	i2c_byte_engine i_i2c_byte_engine (
		.clk       (clk),
		.rst_n     (rst_n),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.tx_byte   (tx_byte),
		.ack_bit   (ack_bit),
		.tick      (tick),
		.phase     (phase),
		.sda_in    (sda_in),
		.run       (run),
		.cmd_done  (cmd_done),
		.rx_byte   (rx_byte),
		.ack_in    (ack_in),
		.scl       (scl),
		.sda_out   (sda_out),
		.sda_oe    (sda_oe)
	);

	i2c_phase_gen i_i2c_phase_gen (
		.clk   (clk),
		.rst_n (rst_n),
		.run   (run),
		.tick  (tick),
		.phase (phase)
	);

endmodule

`default_nettype wire

// File: hw/i2c_txn/i2c_txn_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_txn_ctrl
	import i2c_pkg::*;
(
	input  wire      clk,
	input  wire      rst_n,
	input  wire      start,
	input  wire      rw,
	input  byte_t    reg_addr,
	input  byte_t    write_data,
	input  burst_t   burst_length,
	input  wire      cmd_done,
	input  byte_t    rx_byte,
	input  wire      ack_in,
	output logic     cmd_valid,
	output i2c_cmd_e cmd,
	output byte_t    tx_byte,
	output logic     ack_bit,
	output byte_t    read_data,
	output logic     data_valid,
	output logic     busy,
	output logic     error
);

	txn_state_e state;
	txn_state_e next_state;
	i2c_cmd_e   cmd_d;
	byte_t      tx_d;
	logic       ack_d;
	logic       accept;
	logic       advance;
	logic       nack;
	logic       rw_q;
	byte_t      reg_q;
	byte_t      wdata_q;
	burst_t     rd_left;  // bytes still to read, including the one in flight
	burst_t     rd_next;  // remaining count once the current byte is in

	assign busy    = (state != ST_IDLE);
	assign accept  = (state == ST_IDLE) && start;
	assign advance = accept || (state == ST_DONE) || cmd_done;

	// slave refused an address, register or write byte
	assign nack = ack_in && ((state == ST_ADDR_W) || (state == ST_REG) ||
	                         (state == ST_WDATA) || (state == ST_ADDR_R));

	assign data_valid = cmd_done && (state == ST_RDATA);
	assign read_data  = rx_byte;

	assign rd_next = (state == ST_RDATA) ? rd_left - 4'd1 : rd_left;

	always_comb begin
		next_state = state;
		case (state)
			ST_IDLE:    next_state = ST_START;
			ST_START:   next_state = ST_ADDR_W;
			ST_ADDR_W:  next_state = nack ? ST_STOP : ST_REG;
			ST_REG: begin
				if (nack)
					next_state = ST_STOP;
				else
					next_state = rw_q ? ST_RESTART : ST_WDATA;
			end
			ST_WDATA:   next_state = ST_STOP;
			ST_RESTART: next_state = ST_ADDR_R;
			ST_ADDR_R:  next_state = nack ? ST_STOP : ST_RDATA;
			ST_RDATA:   next_state = (rd_left == 4'd1) ? ST_STOP : ST_RDATA;
			ST_STOP:    next_state = ST_DONE;
			default:    next_state = ST_IDLE;
		endcase
	end

	// command belonging to the state being entered
	always_comb begin
		cmd_d = CMD_STOP;
		tx_d  = '0;
		ack_d = (rd_next == 4'd1); // NACK the last byte of the burst
		case (next_state)
			ST_START:   cmd_d = CMD_START;
			ST_ADDR_W: begin
				cmd_d = CMD_WRITE;
				tx_d  = {SLAVE_ADDR, 1'b0};
			end
			ST_REG: begin
				cmd_d = CMD_WRITE;
				tx_d  = reg_q;
			end
			ST_WDATA: begin
				cmd_d = CMD_WRITE;
				tx_d  = wdata_q;
			end
			ST_RESTART: cmd_d = CMD_RESTART;
			ST_ADDR_R: begin
				cmd_d = CMD_WRITE;
				tx_d  = {SLAVE_ADDR, 1'b1};
			end
			ST_RDATA:   cmd_d = CMD_READ;
			default:    cmd_d = CMD_STOP;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= ST_IDLE;
			cmd_valid <= 1'b0;
			cmd       <= CMD_STOP;
			error     <= 1'b0;
			rd_left   <= '0;
		end else begin
			cmd_valid <= 1'b0;
			if (advance) begin
				state <= next_state;
				if (next_state != ST_DONE && next_state != ST_IDLE) begin
					cmd_valid <= 1'b1;
					cmd       <= cmd_d;
				end
			end
			if (accept) begin
				error   <= 1'b0;
				rd_left <= (burst_length == '0) ? 4'd1 : burst_length;
			end else if (cmd_done) begin
				if (nack)
					error <= 1'b1; // STOP still goes out before busy drops
				if (state == ST_RDATA)
					rd_left <= rd_left - 4'd1;
			end
		end
	end

	// request and command payload
	always_ff @(posedge clk) begin
		if (accept) begin
			rw_q    <= rw;
			reg_q   <= reg_addr;
			wdata_q <= write_data;
		end
		if (advance) begin
			tx_byte <= tx_d;
			ack_bit <= ack_d;
		end
	end

	// read data only comes back from a READ command inside the burst
	a_rdata_only: assert property (
		@(posedge clk) disable iff (!rst_n)
		data_valid |-> (cmd == CMD_READ) && (rd_left != '0)
	) else $error("data_valid outside the read burst");

endmodule

`default_nettype wire

// File: hw/i2c_txn/i2c_byte_engine.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_byte_engine
	import i2c_pkg::*;
(
	input  wire      clk,
	input  wire      rst_n,
	input  wire      cmd_valid,
	input  i2c_cmd_e cmd,
	input  byte_t    tx_byte,
	input  wire      ack_bit,
	input  wire      tick,
	input  phase_t   phase,
	input  wire      sda_in,
	output logic     run,
	output logic     cmd_done,
	output byte_t    rx_byte,
	output logic     ack_in,
	output logic     scl,
	output logic     sda_out,
	output logic     sda_oe
);

	i2c_cmd_e cmd_q;
	bit_cnt_t bit_cnt;
	byte_t    shreg;   // tx bits leave from the top, rx bits enter at the bottom
	logic     ack_q;   // master ack for the current read byte
	logic     last_slot;
	logic     scl_d;
	logic     sda_d;
	logic     oe_d;

	// bus conditions are a single 4-quarter slot
	assign last_slot = (cmd_q == CMD_START) || (cmd_q == CMD_RESTART) ||
	                   (cmd_q == CMD_STOP) || (bit_cnt == 4'd8);

	assign cmd_done = run && tick && (phase == 2'd3) && last_slot;
	assign rx_byte  = shreg;

	// waveform for the current quarter
	always_comb begin
		scl_d = (phase == 2'd1) || (phase == 2'd2); // data slots: SCL high mid slot
		sda_d = 1'b1;
		oe_d  = 1'b1;
		case (cmd_q)
			CMD_START: begin
				scl_d = (phase != 2'd3);
				sda_d = (phase == 2'd0); // falls with SCL high
			end
			CMD_RESTART: begin
				sda_d = (phase == 2'd0) || (phase == 2'd1); // released, then falls in q2
			end
			CMD_STOP: begin
				scl_d = (phase != 2'd0);
				sda_d = phase[1]; // rises in q2 with SCL high
				oe_d  = (phase != 2'd3); // hand the line back to the pull-up
			end
			CMD_WRITE: begin
				if (bit_cnt == 4'd8) begin
					oe_d = 1'b0; // slave acks
				end else begin
					sda_d = shreg[7];
				end
			end
			CMD_READ: begin
				if (bit_cnt == 4'd8) begin
					sda_d = ack_q;
				end else begin
					oe_d = 1'b0; // slave drives data
				end
			end
			default: begin
				oe_d = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			run     <= 1'b0;
			cmd_q   <= CMD_STOP;
			bit_cnt <= '0;
			ack_q   <= 1'b1;
			ack_in  <= 1'b0;
			scl     <= 1'b1;
			sda_out <= 1'b1;
			sda_oe  <= 1'b0;
		end else begin
			if (cmd_valid && !run) begin
				run     <= 1'b1;
				cmd_q   <= cmd;
				bit_cnt <= '0;
				ack_q   <= ack_bit;
			end else if (run) begin
				scl     <= scl_d; // outputs hold their last level between commands
				sda_out <= sda_d;
				sda_oe  <= oe_d;
				if (tick && phase == 2'd2 && cmd_q == CMD_WRITE && bit_cnt == 4'd8) begin
					ack_in <= sda_in; // 1 = NACK
				end
				if (tick && phase == 2'd3) begin
					if (last_slot) begin
						run <= 1'b0;
					end else begin
						bit_cnt <= bit_cnt + 4'd1;
					end
				end
			end
		end
	end

	// shift register, payload only
	always_ff @(posedge clk) begin
		if (cmd_valid && !run) begin
			shreg <= tx_byte;
		end else if (run && tick && bit_cnt != 4'd8) begin
			if (cmd_q == CMD_READ && phase == 2'd2) begin
				shreg <= {shreg[6:0], sda_in}; // sample while SCL high
			end else if (cmd_q == CMD_WRITE && phase == 2'd3) begin
				shreg <= {shreg[6:0], 1'b0}; // next bit up for q0
			end
		end
	end

	// the controller waits for cmd_done before the next command
	a_one_in_flight: assert property (
		@(posedge clk) disable iff (!rst_n)
		run |-> !cmd_valid
	) else $error("cmd_valid while a command is running");

endmodule

`default_nettype wire

// File: hw/i2c_phase_gen.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_phase_gen
	import i2c_pkg::*;
(
	input  wire    clk,
	input  wire    rst_n,
	input  wire    run,
	output logic   tick,
	output phase_t phase
);

	div_cnt_t div_cnt;

	// not gated by run; the engine only drops run right after a final tick
	assign tick = (div_cnt == div_cnt_t'(QUARTER_DIV - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt <= '0;
			phase   <= '0;
		end else if (!run) begin
			div_cnt <= '0; // idle, restart at quarter 0
			phase   <= '0;
		end else if (tick) begin
			div_cnt <= '0;
			phase   <= phase + 2'd1;
		end else begin
			div_cnt <= div_cnt + 16'd1;
		end
	end

	// run must only fall at a quarter boundary, so the divider is at zero whenever idle
	a_no_tick_idle: assert property (
		@(posedge clk) disable iff (!rst_n)
		!run |-> !tick
	) else $error("tick while run is low");

endmodule

`default_nettype wire

// File: common/i2c_pkg.sv
`default_nettype none

package i2c_pkg;

	// bus timing
	localparam int SYS_CLK_HZ  = 50_000_000;
	localparam int I2C_CLK_HZ  = 400_000;
	localparam int QUARTER_DIV = SYS_CLK_HZ / (4 * I2C_CLK_HZ); // 31 clocks per quarter

	// fixed IMU target, AD0 tied low
	localparam logic [6:0] SLAVE_ADDR = 7'h68;

	typedef logic [7:0]  byte_t;    // address, register or data byte on the bus
	typedef logic [3:0]  burst_t;   // burst read length, 0 means one byte
	typedef logic [3:0]  bit_cnt_t; // slot index 0..8, slot 8 is the ack slot
	typedef logic [1:0]  phase_t;   // quarter of the SCL period
	typedef logic [15:0] div_cnt_t; // system clock divider

	// byte engine commands
	typedef enum logic [2:0] {
		CMD_START,
		CMD_RESTART,
		CMD_STOP,
		CMD_WRITE,
		CMD_READ
	} i2c_cmd_e;

	// transaction sequencer states
	typedef enum logic [3:0] {
		ST_IDLE,
		ST_START,
		ST_ADDR_W,  // address + W
		ST_REG,     // register pointer
		ST_WDATA,   // single write byte
		ST_RESTART, // repeated start before read
		ST_ADDR_R,  // address + R
		ST_RDATA,   // burst data bytes
		ST_STOP,
		ST_DONE
	} txn_state_e;

endpackage

`default_nettype wire
